/* common/g729_defines.svh */
`ifndef G729_DEFINES_SVH
`define G729_DEFINES_SVH

// Frame layout
`define PRM_NUM       11
`define SERIAL_SIZE   16'd80

// ITU serial frame words
`define SYNC_WORD     16'h6B21
`define BIT_0         16'h007F
`define BIT_1         16'h0081

// Scratch memory map
`define PARAM_BASE    12'd0
// Size word at OUT_BASE+1, bit k at OUT_BASE+2+k
`define OUT_BASE      12'd16

// Scratch RAM geometry
`define SCRATCH_AW    8
`define SCRATCH_DEPTH 256

`endif

/* common/codec_types_pkg.sv */
package codec_types_pkg;

	////////////////////
	// Data path types
	////////////////////

	// One speech codec data word
	typedef logic [15:0] word16_t;

	// Scratch memory address
	typedef logic [11:0] addr_t;

endpackage

/* common/bitstream_pkg.sv */
package bitstream_pkg;

	////////////////////
	// Bit packing types
	////////////////////

	// Parameter index, 0 to 10
	typedef logic [3:0] field_idx_t;

	// Field width in bits, 1 to 13
	typedef logic [3:0] width_t;

	// Packer sequencer states
	typedef enum logic [2:0]
	{
		IDLE,
		SYNC,
		SIZE,
		FETCH,
		SHIFT,
		FINISH
	} pack_state_t;

endpackage

/* design/scratch_mem.sv */
`include "g729_defines.svh"

module scratch_mem
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     test_sel,
	input  codec_types_pkg::addr_t   core_wr_addr,
	input  codec_types_pkg::word16_t core_wr_data,
	input  logic                     core_wr_en,
	input  codec_types_pkg::addr_t   core_rd_addr,
	input  codec_types_pkg::addr_t   test_wr_addr,
	input  codec_types_pkg::word16_t test_wr_data,
	input  logic                     test_wr_en,
	input  codec_types_pkg::addr_t   test_rd_addr,
	output codec_types_pkg::word16_t rd_data
);

	import codec_types_pkg::*;

	word16_t mem [`SCRATCH_DEPTH];

	addr_t   wr_addr_sel;
	word16_t wr_data_sel;
	logic    wr_en_sel;
	addr_t   rd_addr_sel;

	// Port ownership, test side wins while test_sel is high
	assign wr_addr_sel = test_sel ? test_wr_addr : core_wr_addr;
	assign wr_data_sel = test_sel ? test_wr_data : core_wr_data;
	assign wr_en_sel   = test_sel ? test_wr_en   : core_wr_en;
	assign rd_addr_sel = test_sel ? test_rd_addr : core_rd_addr;

	always_ff @(posedge clock)
	begin
		if (wr_en_sel)
			mem[wr_addr_sel[`SCRATCH_AW-1:0]] <= wr_data_sel;
	end

	// Registered read, one cycle latency
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			rd_data <= '0;
		else
			rd_data <= mem[rd_addr_sel[`SCRATCH_AW-1:0]];
	end

endmodule

/* design/field_width_rom.sv */
module field_width_rom
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  bitstream_pkg::field_idx_t field_idx,
	output bitstream_pkg::width_t     field_width
);

	import bitstream_pkg::*;

	width_t width_lut;

	// G.729 field widths, 80 bits per frame in total
	always_comb
	begin
		case (field_idx)
			4'd0:    width_lut = 4'd8;
			4'd1:    width_lut = 4'd10;
			4'd2:    width_lut = 4'd8;
			4'd3:    width_lut = 4'd1;
			4'd4:    width_lut = 4'd13;
			4'd5:    width_lut = 4'd4;
			4'd6:    width_lut = 4'd7;
			4'd7:    width_lut = 4'd5;
			4'd8:    width_lut = 4'd13;
			4'd9:    width_lut = 4'd4;
			4'd10:   width_lut = 4'd7;
			default: width_lut = 4'd0;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			field_width <= '0;
		else
			field_width <= width_lut;
	end

endmodule

/* prm2bits/prm2bits_ctrl.sv */
`include "g729_defines.svh"

module prm2bits_ctrl
(
	input  logic                      clock,
	input  logic                      rst_n,
	input  logic                      start,
	input  logic                      test_sel,
	input  logic                      bit_valid,
	input  codec_types_pkg::word16_t  bit_word,
	input  logic                      field_last,
	output logic                      done,
	output codec_types_pkg::addr_t    prm_rd_addr,
	output bitstream_pkg::field_idx_t field_idx,
	output logic                      load,
	output codec_types_pkg::addr_t    wr_addr,
	output codec_types_pkg::word16_t  wr_data,
	output logic                      wr_en
);

	import codec_types_pkg::*;
	import bitstream_pkg::*;

	localparam field_idx_t LAST_FIELD = field_idx_t'(`PRM_NUM - 1);

	pack_state_t state;
	pack_state_t state_nxt;
	field_idx_t  field_cnt;
	// Position of the next bit word in the frame, 0 to 79
	logic [6:0]  bit_cnt;

	////////////////////
	// State sequencing
	////////////////////

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
			begin
				// No new run while the test port owns the memory
				if (start && !test_sel)
					state_nxt = SYNC;
			end
			SYNC:   state_nxt = SIZE;
			SIZE:   state_nxt = FETCH;
			FETCH:  state_nxt = SHIFT;
			SHIFT:
			begin
				if (field_last)
					state_nxt = (field_cnt == LAST_FIELD) ? FINISH : FETCH;
			end
			FINISH: state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			field_cnt <= '0;
			bit_cnt   <= '0;
			load      <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			// Both reads land one cycle after FETCH
			load  <= (state == FETCH);
			if (state == IDLE)
			begin
				field_cnt <= '0;
				bit_cnt   <= '0;
			end
			if (state == SHIFT && bit_valid)
				bit_cnt <= bit_cnt + 7'd1;
			if (state == SHIFT && field_last)
				field_cnt <= field_cnt + 4'd1;
		end
	end

	////////////////////
	// Read and write ports
	////////////////////

	// Parameter and width lookups share the field counter
	assign prm_rd_addr = `PARAM_BASE + {8'd0, field_cnt};
	assign field_idx   = field_cnt;
	assign done        = (state == FINISH);

	always_comb
	begin
		wr_en   = 1'b0;
		wr_addr = `OUT_BASE;
		wr_data = bit_word;
		case (state)
			SYNC:
			begin
				wr_en   = 1'b1;
				wr_data = `SYNC_WORD;
			end
			SIZE:
			begin
				wr_en   = 1'b1;
				wr_addr = `OUT_BASE + 12'd1;
				wr_data = `SERIAL_SIZE;
			end
			SHIFT:
			begin
				wr_en   = bit_valid;
				wr_addr = `OUT_BASE + 12'd2 + {5'd0, bit_cnt};
			end
			default: wr_en = 1'b0;
		endcase
	end

endmodule

/* prm2bits/bit_serializer.sv */
`include "g729_defines.svh"

module bit_serializer
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     load,
	input  codec_types_pkg::word16_t prm_value,
	input  bitstream_pkg::width_t    field_width,
	output logic                     bit_valid,
	output codec_types_pkg::word16_t bit_word,
	output logic                     field_last
);

	import codec_types_pkg::*;
	import bitstream_pkg::*;

	width_t     bits_left;
	word16_t    shift_q;
	// Left shift that puts the field MSB at bit 15
	logic [4:0] align;

	assign align = 5'd16 - {1'b0, field_width};

	// Down counter of bits still to send
	always_ff @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
			bits_left <= '0;
		else if (load)
			bits_left <= field_width;
		else if (bits_left != '0)
			bits_left <= bits_left - 4'd1;
	end

	// Bits above the field width fall off the top on load
	always_ff @(posedge clock)
	begin
		if (load)
			shift_q <= prm_value << align;
		else if (bits_left != '0)
			shift_q <= {shift_q[14:0], 1'b0};
	end

	////////////////////
	// Bit word output
	////////////////////

	assign bit_valid  = (bits_left != '0);
	assign field_last = (bits_left == 4'd1);
	// Soft bit word for the ITU serial format
	assign bit_word   = shift_q[15] ? `BIT_1 : `BIT_0;

endmodule

/* design/prm2bits_top.sv */
module prm2bits_top
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     test_sel,
	input  codec_types_pkg::addr_t   test_wr_addr,
	input  codec_types_pkg::word16_t test_wr_data,
	input  logic                     test_wr_en,
	input  codec_types_pkg::addr_t   test_rd_addr,
	output logic                     done,
	output codec_types_pkg::word16_t scratch_rdata
);

	import codec_types_pkg::*;
	import bitstream_pkg::*;

	addr_t      prm_rd_addr;
	addr_t      wr_addr;
	word16_t    wr_data;
	logic       wr_en;
	field_idx_t field_idx;
	width_t     field_width;
	logic       load;
	logic       bit_valid;
	word16_t    bit_word;
	logic       field_last;

	// Parameter store and serial frame output area
	scratch_mem scratch_mem_i
	(
		.clock        (clock),
		.rst_n        (rst_n),
		.test_sel     (test_sel),
		.core_wr_addr (wr_addr),
		.core_wr_data (wr_data),
		.core_wr_en   (wr_en),
		.core_rd_addr (prm_rd_addr),
		.test_wr_addr (test_wr_addr),
		.test_wr_data (test_wr_data),
		.test_wr_en   (test_wr_en),
		.test_rd_addr (test_rd_addr),
		.rd_data      (scratch_rdata)
	);

	field_width_rom field_width_rom_i
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.field_idx   (field_idx),
		.field_width (field_width)
	);

	prm2bits_ctrl prm2bits_ctrl_i
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.start       (start),
		.test_sel    (test_sel),
		.bit_valid   (bit_valid),
		.bit_word    (bit_word),
		.field_last  (field_last),
		.done        (done),
		.prm_rd_addr (prm_rd_addr),
		.field_idx   (field_idx),
		.load        (load),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.wr_en       (wr_en)
	);

	bit_serializer bit_serializer_i
	(
		.clock       (clock),
		.rst_n       (rst_n),
		.load        (load),
		.prm_value   (scratch_rdata),
		.field_width (field_width),
		.bit_valid   (bit_valid),
		.bit_word    (bit_word),
		.field_last  (field_last)
	);

endmodule

/* verif/prm2bits_assert.sv */
`include "g729_defines.svh"

module prm2bits_assert
(
	input logic                       clock,
	input logic                       rst_n,
	input logic                       done,
	input logic                       wr_en,
	input codec_types_pkg::addr_t     wr_addr,
	input logic                       bit_valid,
	input bitstream_pkg::pack_state_t state
);

	import bitstream_pkg::*;

	// Failed assertions so far
	int fail_count;

	initial
	begin
		fail_count = 0;
	end

	done_one_cycle: assert property (@(posedge clock) disable iff (!rst_n) done |=> !done)
		else
		begin
			fail_count++;
			$error("done held for more than one cycle");
		end

	// Packer writes stay in the output area
	wr_above_base: assert property (@(posedge clock) disable iff (!rst_n)
		wr_en |-> wr_addr >= `OUT_BASE)
		else
		begin
			fail_count++;
			$error("core write below the output area");
		end

	bits_in_shift: assert property (@(posedge clock) disable iff (!rst_n)
		bit_valid |-> state == SHIFT)
		else
		begin
			fail_count++;
			$error("bit_valid outside SHIFT");
		end

endmodule

bind prm2bits_ctrl prm2bits_assert assert_i
(
	.clock     (clock),
	.rst_n     (rst_n),
	.done      (done),
	.wr_en     (wr_en),
	.wr_addr   (wr_addr),
	.bit_valid (bit_valid),
	.state     (state)
);

/* verif/prm2bits_monitor.sv */
`include "g729_defines.svh"

module prm2bits_monitor
(
	input  logic                     clock,
	input  logic                     rst_n,
	input  logic                     test_sel,
	input  logic                     test_wr_en,
	input  codec_types_pkg::addr_t   test_wr_addr,
	input  codec_types_pkg::word16_t test_wr_data,
	input  codec_types_pkg::addr_t   test_rd_addr,
	input  logic                     rd_req,
	input  codec_types_pkg::word16_t scratch_rdata,
	input  logic                     start,
	input  logic                     done,
	input  codec_types_pkg::word16_t exp_sync,
	input  codec_types_pkg::word16_t exp_size,
	output int                       error_count,
	output int                       word_count,
	output int                       done_count
);

	import codec_types_pkg::*;

	// G.729 field widths in transmission order
	localparam int FIELD_W [`PRM_NUM] = '{8, 10, 8, 1, 13, 4, 7, 5, 13, 4, 7};
	localparam int OUT_FIRST = 16;

	word16_t shadow [`PRM_NUM];
	logic    pend_valid;
	int      pend_addr;
	int      starts_seen;

	// Bit k of the frame, walking the fields MSB first
	function automatic word16_t expected_bit(input int k);
		int pos;
		logic b;
		pos = 0;
		b = 1'b0;
		for (int f = 0; f < `PRM_NUM; f++)
			for (int j = FIELD_W[f] - 1; j >= 0; j--)
			begin
				if (pos == k)
					b = shadow[f][j];
				pos++;
			end
		return b ? `BIT_1 : `BIT_0;
	endfunction

	function automatic word16_t expected_word(input int addr);
		if (addr < `PRM_NUM)
			return shadow[addr];
		if (addr == OUT_FIRST)
			return exp_sync;
		if (addr == OUT_FIRST + 1)
			return exp_size;
		return expected_bit(addr - OUT_FIRST - 2);
	endfunction

	////////////////////
	// Port capture
	////////////////////

	always @(posedge clock or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pend_valid  <= 1'b0;
			pend_addr   <= 0;
			starts_seen <= 0;
		end
		else
		begin
			pend_valid <= rd_req && test_sel;
			pend_addr  <= int'(test_rd_addr);
			if (test_sel && test_wr_en && test_wr_addr < `PRM_NUM)
				shadow[test_wr_addr] <= test_wr_data;
			if (start && !test_sel)
				starts_seen <= starts_seen + 1;
		end
	end

	////////////////////
	// Compare
	////////////////////

	initial
	begin
		error_count = 0;
		word_count  = 0;
		done_count  = 0;
	end

	// Read data and done are settled by the falling edge
	always @(negedge clock)
	begin
		if (rst_n && pend_valid && (pend_addr < `PRM_NUM || pend_addr >= OUT_FIRST))
		begin
			word_count = word_count + 1;
			if (scratch_rdata !== expected_word(pend_addr))
			begin
				error_count = error_count + 1;
				$display("Error at %0t: address %0d read %h, expected %h",
					$time, pend_addr, scratch_rdata, expected_word(pend_addr));
			end
		end
		if (rst_n && done)
		begin
			done_count = done_count + 1;
			if (done_count > starts_seen)
			begin
				error_count = error_count + 1;
				$display("Error at %0t: done pulse without an accepted start", $time);
			end
		end
	end

endmodule

/* verif/prm2bits_tb.sv */
`include "g729_defines.svh"

module prm2bits_tb;

	import codec_types_pkg::*;

	localparam int FRAMES       = 5;
	localparam int CLK_PERIOD   = 40;
	localparam int DRIVE_DELAY  = 5;
	localparam int READ_LAST    = 97;
	localparam int DONE_LIMIT   = 400;
	localparam int IDLE_WAIT    = 120;
	localparam int WATCHDOG_CYC = FRAMES * 400;
	// One read back per frame plus the one after the blocked start
	localparam int CHECKED_WORDS =
		(FRAMES + 1) * (`PRM_NUM + READ_LAST + 1 - int'(`OUT_BASE));

	logic    clock;
	logic    rst_n;
	logic    start;
	logic    test_sel;
	addr_t   test_wr_addr;
	word16_t test_wr_data;
	logic    test_wr_en;
	addr_t   test_rd_addr;
	logic    rd_req;
	logic    done;
	word16_t scratch_rdata;
	word16_t exp_sync;
	word16_t exp_size;
	int      mon_errors;
	int      mon_words;
	int      mon_dones;
	int      tb_errors;
	int      assert_errors;
	integer  seed;

	// Frame table, parameters and expected header words
	word16_t frame_prm  [FRAMES][`PRM_NUM];
	word16_t frame_sync [FRAMES];
	word16_t frame_size [FRAMES];

	prm2bits_top dut_i
	(
		.clock         (clock),
		.rst_n         (rst_n),
		.start         (start),
		.test_sel      (test_sel),
		.test_wr_addr  (test_wr_addr),
		.test_wr_data  (test_wr_data),
		.test_wr_en    (test_wr_en),
		.test_rd_addr  (test_rd_addr),
		.done          (done),
		.scratch_rdata (scratch_rdata)
	);

	prm2bits_monitor mon_i
	(
		.clock         (clock),
		.rst_n         (rst_n),
		.test_sel      (test_sel),
		.test_wr_en    (test_wr_en),
		.test_wr_addr  (test_wr_addr),
		.test_wr_data  (test_wr_data),
		.test_rd_addr  (test_rd_addr),
		.rd_req        (rd_req),
		.scratch_rdata (scratch_rdata),
		.start         (start),
		.done          (done),
		.exp_sync      (exp_sync),
		.exp_size      (exp_size),
		.error_count   (mon_errors),
		.word_count    (mon_words),
		.done_count    (mon_dones)
	);

	always #(CLK_PERIOD / 2) clock = ~clock;

	task build_table;
		for (int f = 0; f < FRAMES; f++)
		begin
			frame_sync[f] = 16'h6B21;
			frame_size[f] = 16'd80;
			for (int i = 0; i < `PRM_NUM; i++)
			begin
				case (f)
					0: frame_prm[f][i] = 16'h0000;
					1: frame_prm[f][i] = 16'hFFFF;
					2: frame_prm[f][i] = (i % 2 == 0) ? 16'hAAAA : 16'h5555;
					default: frame_prm[f][i] = word16_t'($random(seed));
				endcase
			end
		end
	endtask

	////////////////////
	// Stimulus tasks
	////////////////////

	task load_frame(input int f);
		for (int i = 0; i < `PRM_NUM; i++)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			test_sel     = 1'b1;
			test_wr_en   = 1'b1;
			test_wr_addr = `PARAM_BASE + addr_t'(i);
			test_wr_data = frame_prm[f][i];
		end
		@(posedge clock);
		#DRIVE_DELAY;
		test_wr_en = 1'b0;
	endtask

	task run_frame(input int f);
		logic got;
		got = 1'b0;
		@(posedge clock);
		#DRIVE_DELAY;
		test_sel = 1'b0;
		start    = 1'b1;
		@(posedge clock);
		#DRIVE_DELAY;
		start = 1'b0;
		for (int c = 0; c < DONE_LIMIT && !got; c++)
		begin
			@(negedge clock);
			if (done)
				got = 1'b1;
		end
		if (!got)
		begin
			tb_errors = tb_errors + 1;
			$display("Timeout: frame %0d never signalled done", f);
		end
	endtask

	task read_back;
		for (int a = 0; a <= READ_LAST; a++)
		begin
			@(posedge clock);
			#DRIVE_DELAY;
			test_sel     = 1'b1;
			rd_req       = 1'b1;
			test_rd_addr = addr_t'(a);
		end
		@(posedge clock);
		#DRIVE_DELAY;
		rd_req = 1'b0;
		repeat (2) @(posedge clock);
	endtask

	// Start while the test port owns the memory must be ignored
	task blocked_start;
		@(posedge clock);
		#DRIVE_DELAY;
		test_sel = 1'b1;
		start    = 1'b1;
		@(posedge clock);
		#DRIVE_DELAY;
		start = 1'b0;
		repeat (IDLE_WAIT) @(posedge clock);
	endtask

	initial
	begin
		repeat (WATCHDOG_CYC) @(posedge clock);
		$display("Watchdog expired: the run took far longer than the tests need");
		$display("Done: errors found");
		$finish;
	end

	initial
	begin
		clock         = 1'b0;
		rst_n         = 1'b0;
		start         = 1'b0;
		test_sel      = 1'b0;
		test_wr_addr  = '0;
		test_wr_data  = '0;
		test_wr_en    = 1'b0;
		test_rd_addr  = '0;
		rd_req        = 1'b0;
		exp_sync      = '0;
		exp_size      = '0;
		tb_errors     = 0;
		assert_errors = 0;
		seed          = 32'h8556_61a6;
		build_table();
		repeat (2) @(posedge clock);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// Back to back frames, no reset in between
		for (int f = 0; f < FRAMES; f++)
		begin
			load_frame(f);
			exp_sync = frame_sync[f];
			exp_size = frame_size[f];
			run_frame(f);
			read_back();
			if (f == 0)
			begin
				blocked_start();
				read_back();
			end
		end

		repeat (2) @(posedge clock);
		// One done per accepted start, and every read back word compared
		if (mon_dones != FRAMES)
		begin
			tb_errors = tb_errors + 1;
			$display("Error at %0t: %0d done pulses for %0d frames",
				$time, mon_dones, FRAMES);
		end
		if (mon_words != CHECKED_WORDS)
		begin
			tb_errors = tb_errors + 1;
			$display("Error at %0t: %0d words compared, expected %0d",
				$time, mon_words, CHECKED_WORDS);
		end
		assert_errors = dut_i.prm2bits_ctrl_i.assert_i.fail_count;
		$display({"Closing: %0d words checked, %0d done pulses, %0d monitor errors, ",
			"%0d testbench errors, %0d assertion errors"},
			mon_words, mon_dones, mon_errors, tb_errors, assert_errors);
		if (mon_errors + tb_errors + assert_errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* src.f */
+incdir+common
common/codec_types_pkg.sv
common/bitstream_pkg.sv
design/scratch_mem.sv
design/field_width_rom.sv
prm2bits/prm2bits_ctrl.sv
prm2bits/bit_serializer.sv
design/prm2bits_top.sv
verif/prm2bits_assert.sv
verif/prm2bits_monitor.sv
verif/prm2bits_tb.sv
